// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_axi4_adapter
RTL_TOP   ?= axi4_adapter
FILELIST  ?= axi4_adapter.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RTL_SRCS  ?= source/axi_pkg.sv source/adapter_pkg.sv source/adapter_ctrl.sv \
             source/w_beat_sender.sv source/r_line_collector.sv source/axi4_adapter.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall +incdir+source $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== axi4_adapter.f ====
+incdir+source
source/axi_pkg.sv
source/adapter_pkg.sv
source/adapter_ctrl.sv
source/w_beat_sender.sv
source/r_line_collector.sv
source/axi4_adapter.sv
tests/axi4_adapter_sva.sv
tests/adapter_checker.sv
tests/tb_axi4_adapter.sv

// ==== source/adapter_ctrl.sv ====
// request inputs must stay stable until gnt_o; a B with an ID other than the AW ID is not taken
`include "axi4_adapter_cfg.svh"

module adapter_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_i,
  input  adapter_pkg::req_kind_t kind_i,
  input  logic                   we_i,
  input  axi_pkg::axi_addr_t     addr_i,
  input  axi_pkg::axi_size_t     size_i,
  input  axi_pkg::axi_id_t       id_i,
  input  logic                   w_done_i,
  input  logic                   r_last_seen_i,
  input  logic                   aw_ready_i,
  input  logic                   ar_ready_i,
  input  logic                   b_valid_i,
  input  axi_pkg::axi_id_t       b_id_i,
  output logic                   w_start_o,
  output logic                   r_start_o,
  output logic                   aw_valid_o,
  output axi_pkg::axi_addr_t     aw_addr_o,
  output axi_pkg::axi_len_t      aw_len_o,
  output axi_pkg::axi_size_t     aw_size_o,
  output axi_pkg::axi_burst_t    aw_burst_o,
  output axi_pkg::axi_cache_t    aw_cache_o,
  output axi_pkg::axi_id_t       aw_id_o,
  output logic                   ar_valid_o,
  output axi_pkg::axi_addr_t     ar_addr_o,
  output axi_pkg::axi_len_t      ar_len_o,
  output axi_pkg::axi_size_t     ar_size_o,
  output axi_pkg::axi_burst_t    ar_burst_o,
  output axi_pkg::axi_cache_t    ar_cache_o,
  output axi_pkg::axi_id_t       ar_id_o,
  output logic                   b_ready_o,
  output logic                   gnt_o,
  output logic                   busy_o,
  output logic                   b_resp_valid_o
);

  import axi_pkg::*;
  import adapter_pkg::*;

  // keeps the bits above the line offset
  localparam axi_addr_t LINE_MASK = {`AXI_ADDR_WIDTH{1'b1}} << `LINE_BYTE_OFFSET;

  ctrl_state_t state_q, state_d;
  axi_id_t     aw_id_q;
  axi_len_t    burst_len;

  // --------------------
  // address channels
  // --------------------
  assign burst_len = (kind_i == REQ_LINE) ? axi_len_t'(BEATS_PER_LINE - 1) : '0;

  assign aw_addr_o  = addr_i;
  assign aw_len_o   = burst_len;
  assign aw_size_o  = size_i;
  assign aw_burst_o = BURST_INCR;
  assign aw_cache_o = CACHE_MODIFIABLE;
  assign aw_id_o    = id_i;

  // line reads start at the line base
  assign ar_addr_o  = (kind_i == REQ_LINE) ? (addr_i & LINE_MASK) : addr_i;
  assign ar_len_o   = burst_len;
  assign ar_size_o  = size_i;
  assign ar_burst_o = BURST_INCR;
  assign ar_cache_o = CACHE_MODIFIABLE;
  assign ar_id_o    = id_i;

  assign busy_o = (state_q != IDLE);

  // only the response to our own write is accepted
  assign b_ready_o      = (state_q == WAIT_B) && (b_id_i == aw_id_q);
  assign b_resp_valid_o = b_ready_o && b_valid_i;

  // --------------------
  // state machine
  // --------------------
  always_comb begin
    state_d    = state_q;
    aw_valid_o = 1'b0;
    ar_valid_o = 1'b0;
    w_start_o  = 1'b0;
    r_start_o  = 1'b0;
    gnt_o      = 1'b0;

    case (state_q)
      IDLE: begin
        if (req_i && we_i) begin
          aw_valid_o = 1'b1;
          w_start_o  = 1'b1;
          // AW and the last W beat may finish in either order
          case ({aw_ready_i, w_done_i})
            2'b11: begin
              gnt_o   = 1'b1;
              state_d = WAIT_B;
            end
            2'b10:   state_d = WAIT_W;
            2'b01:   state_d = WAIT_AW;
            default: state_d = WAIT_AW_W;
          endcase
        end else if (req_i) begin
          ar_valid_o = 1'b1;
          if (ar_ready_i) begin
            gnt_o     = 1'b1;
            r_start_o = 1'b1;
            state_d   = WAIT_R;
          end
        end
      end

      WAIT_AW_W: begin
        aw_valid_o = 1'b1;
        case ({aw_ready_i, w_done_i})
          2'b11: begin
            gnt_o   = 1'b1;
            state_d = WAIT_B;
          end
          2'b10:   state_d = WAIT_W;
          2'b01:   state_d = WAIT_AW;
          default: state_d = WAIT_AW_W;
        endcase
      end

      // W burst already complete
      WAIT_AW: begin
        aw_valid_o = 1'b1;
        if (aw_ready_i) begin
          gnt_o   = 1'b1;
          state_d = WAIT_B;
        end
      end

      WAIT_W: begin
        if (w_done_i) begin
          gnt_o   = 1'b1;
          state_d = WAIT_B;
        end
      end

      WAIT_B: begin
        if (b_resp_valid_o) begin
          state_d = IDLE;
        end
      end

      WAIT_R: begin
        if (r_last_seen_i) begin
          state_d = READ_DONE;
        end
      end

      // collector returns the line in this cycle
      READ_DONE: state_d = IDLE;

      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ID of the write in flight, matched against B
  always_ff @(posedge clk_i) begin
    if (aw_valid_o && aw_ready_i) begin
      aw_id_q <= id_i;
    end
  end

endmodule

// ==== source/adapter_pkg.sv ====
// request-side types; a line is BEATS_PER_LINE whole AXI beats, word 0 at the lowest address
`include "axi4_adapter_cfg.svh"

package adapter_pkg;

  localparam int unsigned BEATS_PER_LINE = `LINE_WIDTH / `AXI_DATA_WIDTH;
  localparam int unsigned BEAT_IDX_WIDTH = (BEATS_PER_LINE > 1) ? $clog2(BEATS_PER_LINE) : 1;

  // beat position inside a line
  typedef logic [BEAT_IDX_WIDTH-1:0] beat_idx_t;

  typedef axi_pkg::axi_data_t [BEATS_PER_LINE-1:0] line_data_t;
  typedef axi_pkg::axi_strb_t [BEATS_PER_LINE-1:0] line_strb_t;

  typedef enum logic {
    REQ_SINGLE = 1'b0,
    REQ_LINE   = 1'b1
  } req_kind_t;

  // WAIT_AW, WAIT_W and WAIT_AW_W name what is still missing of a write
  typedef enum logic [2:0] {
    IDLE,
    WAIT_AW,
    WAIT_W,
    WAIT_AW_W,
    WAIT_B,
    WAIT_R,
    READ_DONE
  } ctrl_state_t;

endpackage

// ==== source/axi4_adapter.sv ====
// one transaction in flight; b_resp_i is not interpreted, so every write response completes
module axi4_adapter (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  // request side
  input  logic                    req_i,
  input  adapter_pkg::req_kind_t  kind_i,
  input  logic                    we_i,
  input  axi_pkg::axi_addr_t      addr_i,
  input  axi_pkg::axi_size_t      size_i,
  input  axi_pkg::axi_id_t        id_i,
  input  adapter_pkg::line_data_t wdata_i,
  input  adapter_pkg::line_strb_t be_i,
  output logic                    gnt_o,
  output logic                    busy_o,
  output logic                    valid_o,
  output adapter_pkg::line_data_t rdata_o,
  output axi_pkg::axi_id_t        id_o,

  // write address
  output logic                    aw_valid_o,
  input  logic                    aw_ready_i,
  output axi_pkg::axi_addr_t      aw_addr_o,
  output axi_pkg::axi_len_t       aw_len_o,
  output axi_pkg::axi_size_t      aw_size_o,
  output axi_pkg::axi_burst_t     aw_burst_o,
  output axi_pkg::axi_cache_t     aw_cache_o,
  output axi_pkg::axi_id_t        aw_id_o,

  // write data
  output logic                    w_valid_o,
  input  logic                    w_ready_i,
  output axi_pkg::axi_data_t      w_data_o,
  output axi_pkg::axi_strb_t      w_strb_o,
  output logic                    w_last_o,

  // write response
  input  logic                    b_valid_i,
  output logic                    b_ready_o,
  input  axi_pkg::axi_id_t        b_id_i,
  input  axi_pkg::axi_resp_t      b_resp_i,

  // read address
  output logic                    ar_valid_o,
  input  logic                    ar_ready_i,
  output axi_pkg::axi_addr_t      ar_addr_o,
  output axi_pkg::axi_len_t       ar_len_o,
  output axi_pkg::axi_size_t      ar_size_o,
  output axi_pkg::axi_burst_t     ar_burst_o,
  output axi_pkg::axi_cache_t     ar_cache_o,
  output axi_pkg::axi_id_t        ar_id_o,

  // read data
  input  logic                    r_valid_i,
  output logic                    r_ready_o,
  input  axi_pkg::axi_data_t      r_data_i,
  input  axi_pkg::axi_id_t        r_id_i,
  input  logic                    r_last_i
);

  // controller handshakes with the two data-path blocks
  logic w_start;
  logic w_done;
  logic r_start;
  logic r_last_seen;
  logic b_resp_valid;

  adapter_ctrl u_adapter_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .kind_i         (kind_i),
    .we_i           (we_i),
    .addr_i         (addr_i),
    .size_i         (size_i),
    .id_i           (id_i),
    .w_done_i       (w_done),
    .r_last_seen_i  (r_last_seen),
    .aw_ready_i     (aw_ready_i),
    .ar_ready_i     (ar_ready_i),
    .b_valid_i      (b_valid_i),
    .b_id_i         (b_id_i),
    .w_start_o      (w_start),
    .r_start_o      (r_start),
    .aw_valid_o     (aw_valid_o),
    .aw_addr_o      (aw_addr_o),
    .aw_len_o       (aw_len_o),
    .aw_size_o      (aw_size_o),
    .aw_burst_o     (aw_burst_o),
    .aw_cache_o     (aw_cache_o),
    .aw_id_o        (aw_id_o),
    .ar_valid_o     (ar_valid_o),
    .ar_addr_o      (ar_addr_o),
    .ar_len_o       (ar_len_o),
    .ar_size_o      (ar_size_o),
    .ar_burst_o     (ar_burst_o),
    .ar_cache_o     (ar_cache_o),
    .ar_id_o        (ar_id_o),
    .b_ready_o      (b_ready_o),
    .gnt_o          (gnt_o),
    .busy_o         (busy_o),
    .b_resp_valid_o (b_resp_valid)
  );

  w_beat_sender u_w_beat_sender (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .start_i   (w_start),
    .kind_i    (kind_i),
    .wdata_i   (wdata_i),
    .be_i      (be_i),
    .w_ready_i (w_ready_i),
    .w_valid_o (w_valid_o),
    .w_data_o  (w_data_o),
    .w_strb_o  (w_strb_o),
    .w_last_o  (w_last_o),
    .done_o    (w_done)
  );

  r_line_collector u_r_line_collector (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .start_i        (r_start),
    .kind_i         (kind_i),
    .r_valid_i      (r_valid_i),
    .r_data_i       (r_data_i),
    .r_id_i         (r_id_i),
    .r_last_i       (r_last_i),
    .b_resp_valid_i (b_resp_valid),
    .b_id_i         (b_id_i),
    .r_ready_o      (r_ready_o),
    .last_seen_o    (r_last_seen),
    .valid_o        (valid_o),
    .rdata_o        (rdata_o),
    .id_o           (id_o)
  );

endmodule

// ==== source/axi4_adapter_cfg.svh ====
// widths must divide evenly: LINE_WIDTH a whole number of beats, data width a multiple of 8
`ifndef AXI4_ADAPTER_CFG_SVH
`define AXI4_ADAPTER_CFG_SVH

// --------------------
// line geometry
// --------------------
// cache line width in bits
`define LINE_WIDTH 256
// low address bits cleared on a line read, log2 of the line size in bytes
`define LINE_BYTE_OFFSET 5

// --------------------
// AXI widths
// --------------------
`define AXI_DATA_WIDTH 64
`define AXI_ADDR_WIDTH 32
`define AXI_ID_WIDTH 4

`endif

// ==== source/axi_pkg.sv ====
// AXI4 field types for this bridge only; lock, prot, region, qos and user are not carried
`include "axi4_adapter_cfg.svh"

package axi_pkg;

  // --------------------
  // channel fields
  // --------------------
  typedef logic [`AXI_ADDR_WIDTH-1:0]   axi_addr_t;
  typedef logic [`AXI_DATA_WIDTH-1:0]   axi_data_t;
  typedef logic [`AXI_DATA_WIDTH/8-1:0] axi_strb_t;
  typedef logic [`AXI_ID_WIDTH-1:0]     axi_id_t;
  typedef logic [7:0]                   axi_len_t;
  typedef logic [2:0]                   axi_size_t;
  typedef logic [1:0]                   axi_burst_t;
  typedef logic [1:0]                   axi_resp_t;
  typedef logic [3:0]                   axi_cache_t;

  // --------------------
  // encodings
  // --------------------
  // incrementing burst, used for both single beats and lines
  localparam axi_burst_t BURST_INCR = 2'b01;

  localparam axi_resp_t RESP_OKAY = 2'b00;

  // normal non-cacheable bufferable is not needed, modifiable is enough
  localparam axi_cache_t CACHE_MODIFIABLE = 4'b0010;

endpackage

// ==== source/r_line_collector.sv ====
// R beats arrive in address order; rdata_o holds the last read line until the next read
module r_line_collector (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    start_i,
  input  adapter_pkg::req_kind_t  kind_i,
  input  logic                    r_valid_i,
  input  axi_pkg::axi_data_t      r_data_i,
  input  axi_pkg::axi_id_t        r_id_i,
  input  logic                    r_last_i,
  input  logic                    b_resp_valid_i,
  input  axi_pkg::axi_id_t        b_id_i,
  output logic                    r_ready_o,
  output logic                    last_seen_o,
  output logic                    valid_o,
  output adapter_pkg::line_data_t rdata_o,
  output axi_pkg::axi_id_t        id_o
);

  import axi_pkg::*;
  import adapter_pkg::*;

  logic       active_q;
  req_kind_t  kind_q;
  beat_idx_t  cnt_q;
  logic       valid_q;
  logic       r_hs;
  beat_idx_t  widx;
  line_data_t line_q;
  axi_id_t    id_q;

  assign r_ready_o   = active_q;
  assign r_hs        = r_valid_i && active_q;
  assign last_seen_o = r_hs && r_last_i;

  // a single read always lands in word 0
  assign widx = (kind_q == REQ_LINE) ? cnt_q : '0;

  // --------------------
  // response mux
  // --------------------
  assign valid_o = valid_q || b_resp_valid_i;
  assign id_o    = valid_q ? id_q : b_id_i;
  assign rdata_o = line_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      kind_q   <= REQ_SINGLE;
      cnt_q    <= '0;
      valid_q  <= 1'b0;
    end else begin
      valid_q <= last_seen_o;
      if (start_i) begin
        // request inputs may change after the AR grant
        active_q <= 1'b1;
        kind_q   <= kind_i;
        cnt_q    <= '0;
      end else if (r_hs) begin
        if (r_last_i) begin
          active_q <= 1'b0;
        end else begin
          cnt_q <= beat_idx_t'(cnt_q + 1'b1);
        end
      end
    end
  end

  // line buffer and captured ID
  always_ff @(posedge clk_i) begin
    if (r_hs) begin
      line_q[widx] <= r_data_i;
    end
    if (last_seen_o) begin
      id_q <= r_id_i;
    end
  end

endmodule

// ==== source/w_beat_sender.sv ====
// wdata_i, be_i and kind_i are read live and must hold until the last W beat is accepted
module w_beat_sender (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    start_i,
  input  adapter_pkg::req_kind_t  kind_i,
  input  adapter_pkg::line_data_t wdata_i,
  input  adapter_pkg::line_strb_t be_i,
  input  logic                    w_ready_i,
  output logic                    w_valid_o,
  output axi_pkg::axi_data_t      w_data_o,
  output axi_pkg::axi_strb_t      w_strb_o,
  output logic                    w_last_o,
  output logic                    done_o
);

  import adapter_pkg::*;

  localparam beat_idx_t LAST_BEAT = beat_idx_t'(BEATS_PER_LINE - 1);

  logic      busy_q;
  beat_idx_t cnt_q;
  beat_idx_t idx;

  // first beat goes out in the start cycle
  assign idx       = busy_q ? cnt_q : '0;
  assign w_valid_o = start_i || busy_q;
  assign w_data_o  = wdata_i[idx];
  assign w_strb_o  = be_i[idx];
  assign w_last_o  = (kind_i == REQ_SINGLE) || (idx == LAST_BEAT);
  assign done_o    = w_valid_o && w_ready_i && w_last_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (w_valid_o) begin
      if (w_ready_i) begin
        busy_q <= !w_last_o;
        cnt_q  <= w_last_o ? '0 : beat_idx_t'(idx + 1'b1);
      end else begin
        // stalled beat stays on the bus
        busy_q <= 1'b1;
        cnt_q  <= idx;
      end
    end
  end

endmodule

// ==== tests/adapter_cases.txt ====
// op(1 write, 0 read) kind(1 line, 0 single) addr id data0..data3 strb0..strb3
// single requests use data0 and strb0 only, all values hex
1 0 00001008 1 1122334455667788 0 0 0 0f 0 0 0
0 0 00001008 2 0 0 0 0 0 0 0 0
1 1 00002000 3 a0a0a0a0a0a0a0a0 b1b1b1b1b1b1b1b1 c2c2c2c2c2c2c2c2 d3d3d3d3d3d3d3d3 ff ff ff ff
0 1 00002018 4 0 0 0 0 0 0 0 0
1 1 00003000 5 0123456789abcdef fedcba9876543210 0f1e2d3c4b5a6978 8877665544332211 f0 0f ff 00
0 1 00003000 6 0 0 0 0 0 0 0 0
0 0 00004010 7 0 0 0 0 0 0 0 0
1 0 00004010 8 deadbeefcafef00d 0 0 0 81 0 0 0
0 0 00004010 9 0 0 0 0 0 0 0 0
0 1 00004000 a 0 0 0 0 0 0 0 0
1 0 00002008 b 5555aaaa5555aaaa 0 0 0 ff 0 0 0
0 1 00002000 c 0 0 0 0 0 0 0 0
1 1 00005000 d 1111111111111111 2222222222222222 3333333333333333 4444444444444444 3c c3 aa 55
0 1 0000501f e 0 0 0 0 0 0 0 0
0 0 00005018 f 0 0 0 0 0 0 0 0
1 0 00006000 0 0badc0de0badc0de 0 0 0 01 0 0 0
0 1 00006008 1 0 0 0 0 0 0 0 0

// ==== tests/adapter_checker.sv ====
// memory starts from the same address-derived fill as the subordinate model; 8-byte words only
`include "axi4_adapter_cfg.svh"

module adapter_checker (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    req_i, we_i, gnt_i, busy_i, valid_i,
  input  adapter_pkg::req_kind_t  kind_i,
  input  axi_pkg::axi_addr_t      addr_i, ar_addr_i,
  input  axi_pkg::axi_id_t        id_i, rid_i, b_id_i,
  input  adapter_pkg::line_data_t wdata_i, rdata_i,
  input  adapter_pkg::line_strb_t be_i,
  input  axi_pkg::axi_size_t      size_i, aw_size_i, ar_size_i,
  input  axi_pkg::axi_cache_t     aw_cache_i, ar_cache_i,
  input  logic                    aw_valid_i, aw_ready_i, w_valid_i, b_valid_i, b_ready_i,
  input  logic                    ar_valid_i, ar_ready_i, r_valid_i, r_ready_i, r_last_i,
  input  axi_pkg::axi_len_t       aw_len_i, ar_len_i,
  input  axi_pkg::axi_burst_t     aw_burst_i, ar_burst_i,
  output int unsigned             done_o,
  output int unsigned             errors_o
);

  import axi_pkg::*;
  import adapter_pkg::*;

  axi_data_t shadow [int unsigned];
  bit        pend;
  bit        pend_we;
  bit        rlast_q;
  bit        test_ok = 1'b1;
  req_kind_t pend_kind;
  axi_addr_t pend_addr;
  axi_id_t   pend_id;

  function automatic axi_data_t shadow_word(input int unsigned wa);
    return shadow.exists(wa) ? shadow[wa] : {wa ^ 32'ha5a5_0f0f, wa * 32'h9e37_79b1};
  endfunction

  // one byte lane of ones per set strobe
  function automatic axi_data_t byte_mask(input axi_strb_t s);
    axi_data_t m;
    axi_strb_t t;
    m = '0;
    t = s;
    for (int b = 0; b < `AXI_DATA_WIDTH / 8; b++) begin
      m = {(t[0] ? 8'hff : 8'h00), m[`AXI_DATA_WIDTH-1:8]};
      t = t >> 1;
    end
    return m;
  endfunction

  function automatic axi_addr_t line_base(input axi_addr_t a);
    return {a[`AXI_ADDR_WIDTH-1:`LINE_BYTE_OFFSET], {`LINE_BYTE_OFFSET{1'b0}}};
  endfunction

  function automatic axi_len_t exp_len(input req_kind_t k);
    return (k == REQ_LINE) ? axi_len_t'(`LINE_WIDTH / `AXI_DATA_WIDTH - 1) : '0;
  endfunction

  function automatic void report_error(input string msg);
    $display("** Error @%0t: %s", $time, msg);
    errors_o++;
    test_ok = 1'b0;
  endfunction

  // --------------------
  // shadow memory
  // --------------------
  function automatic void update_shadow();
    int unsigned wa;
    line_data_t  d;
    line_strb_t  s;
    axi_data_t   m;
    wa = addr_i >> 3;
    d = wdata_i;
    s = be_i;
    for (int unsigned i = 0; i < BEATS_PER_LINE; i++) begin
      if (kind_i == REQ_LINE || i == 0) begin
        m = byte_mask(s[0]);
        shadow[wa + i] = (shadow_word(wa + i) & ~m) | (d[0] & m);
      end
      d = d >> `AXI_DATA_WIDTH;
      s = s >> (`AXI_DATA_WIDTH / 8);
    end
  endfunction

  task automatic check_response();
    int unsigned wa;
    line_data_t  l;
    if (!pend) begin
      report_error("response without a granted request");
      return;
    end
    if (!busy_i) report_error("busy low at the response");
    if (pend_we) begin
      if (!(b_valid_i && b_ready_i)) report_error("write response outside the B handshake");
      if (rid_i != b_id_i || rid_i != pend_id) report_error("write response ID wrong");
    end else begin
      if (!rlast_q) report_error("read response not one cycle after the last R beat");
      if (rid_i != pend_id) report_error("read response ID wrong");
      wa = (pend_kind == REQ_LINE) ? (line_base(pend_addr) >> 3) : (pend_addr >> 3);
      l = rdata_i;
      for (int unsigned i = 0; i < BEATS_PER_LINE; i++) begin
        if ((pend_kind == REQ_LINE || i == 0) && l[0] != shadow_word(wa + i)) begin
          report_error($sformatf("read word %0d is %h, expected %h", i, l[0], shadow_word(wa + i)));
        end
        l = l >> `AXI_DATA_WIDTH;
      end
    end
    done_o++;
    $display("test %0d: %s %s addr %h id %h %s", done_o, pend_we ? "write" : "read",
             (pend_kind == REQ_LINE) ? "line" : "single", pend_addr, pend_id,
             test_ok ? "ok" : "FAIL");
    pend = 1'b0;
    test_ok = 1'b1;
  endtask

  // --------------------
  // sampling
  // --------------------
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      if (gnt_i || busy_i || valid_i || aw_valid_i || w_valid_i || ar_valid_i) begin
        report_error("DUT output active during reset");
      end
    end else begin
      if (aw_valid_i && aw_ready_i) begin
        if (aw_len_i != exp_len(kind_i) || aw_burst_i != BURST_INCR) begin
          report_error("AW len or burst wrong");
        end
        if (aw_size_i != size_i || aw_cache_i != CACHE_MODIFIABLE) begin
          report_error("AW size or cache wrong");
        end
      end
      if (ar_valid_i && ar_ready_i) begin
        if (ar_len_i != exp_len(kind_i) || ar_burst_i != BURST_INCR) begin
          report_error("AR len or burst wrong");
        end
        if (ar_size_i != size_i || ar_cache_i != CACHE_MODIFIABLE) begin
          report_error("AR size or cache wrong");
        end
        if (ar_addr_i != ((kind_i == REQ_LINE) ? line_base(addr_i) : addr_i)) begin
          report_error("AR addr wrong");
        end
      end
      if (gnt_i) begin
        if (!req_i) report_error("grant without a request");
        if (pend) report_error("second grant before the response");
        pend = 1'b1;
        pend_we = we_i;
        pend_kind = kind_i;
        pend_addr = addr_i;
        pend_id = id_i;
        if (we_i) update_shadow();
      end
      if (valid_i) begin
        check_response();
      end else if (rlast_q) begin
        report_error("no response one cycle after the last R beat");
      end
      rlast_q = r_valid_i && r_ready_i && r_last_i;
    end
  end

endmodule

// ==== tests/axi4_adapter_sva.sv ====
// covers the AW and AR valids of the controller and the subordinate's B valid only
module axi4_adapter_sva (
  input logic clk_i,
  input logic rst_ni,
  input logic aw_valid_i,
  input logic aw_ready_i,
  input logic ar_valid_i,
  input logic ar_ready_i,
  input logic b_valid_i,
  input logic b_ready_i
);

  // a raised valid stays up until its transfer
  property hold_until_ready(v, r);
    @(posedge clk_i) disable iff (!rst_ni) v && !r |=> v;
  endproperty

  aw_held: assert property (hold_until_ready(aw_valid_i, aw_ready_i))
    else $error("AW valid dropped before ready");
  ar_held: assert property (hold_until_ready(ar_valid_i, ar_ready_i))
    else $error("AR valid dropped before ready");
  b_held: assert property (hold_until_ready(b_valid_i, b_ready_i))
    else $error("B valid dropped before ready");

  reset_quiet: assert property (@(posedge clk_i) !rst_ni |-> !aw_valid_i && !ar_valid_i && !b_valid_i)
    else $error("AXI valid high during reset");

endmodule

bind adapter_ctrl axi4_adapter_sva u_axi4_adapter_sva (
  .clk_i(clk_i), .rst_ni(rst_ni), .aw_valid_i(aw_valid_o), .aw_ready_i(aw_ready_i),
  .ar_valid_i(ar_valid_o), .ar_ready_i(ar_ready_i), .b_valid_i(b_valid_i), .b_ready_i(b_ready_o)
);

// ==== tests/tb_axi4_adapter.sv ====
// run from the project root; the subordinate model serves one burst at a time, 8-byte beats
module tb_axi4_adapter;

  import axi_pkg::*;
  import adapter_pkg::*;

  localparam int unsigned PERIOD = 4;
  localparam int unsigned CYCLES_PER_CASE = 200;

  logic clk_i = 1'b0;
  logic rst_ni = 1'b0;
  logic req_i = 1'b0;
  logic we_i = 1'b0;
  req_kind_t kind_i = REQ_SINGLE;
  axi_addr_t addr_i = '0;
  axi_size_t size_i = 3'd3;
  axi_id_t id_i = '0;
  line_data_t wdata_i = '0;
  line_strb_t be_i = '0;
  logic gnt_o, busy_o, valid_o;
  line_data_t rdata_o;
  axi_id_t id_o, aw_id_o, ar_id_o;
  logic aw_valid_o, w_valid_o, w_last_o, b_ready_o, ar_valid_o, r_ready_o;
  axi_addr_t aw_addr_o, ar_addr_o;
  axi_len_t aw_len_o, ar_len_o;
  axi_size_t aw_size_o, ar_size_o;
  axi_burst_t aw_burst_o, ar_burst_o;
  axi_cache_t aw_cache_o, ar_cache_o;
  axi_data_t w_data_o;
  axi_strb_t w_strb_o;
  logic aw_ready_i = 1'b0;
  logic w_ready_i = 1'b0;
  logic ar_ready_i = 1'b0;
  logic b_valid_i = 1'b0;
  logic r_valid_i = 1'b0;
  logic r_last_i = 1'b0;
  axi_id_t b_id_i = '0;
  axi_id_t r_id_i = '0;
  axi_resp_t b_resp_i = RESP_OKAY;
  axi_data_t r_data_i = '0;

  logic [63:0] cases [1024];
  int unsigned num_cases;
  int unsigned done;
  int unsigned errors;
  bit loaded;

  // subordinate model state
  axi_data_t mem [int unsigned];
  axi_data_t w_buf [$];
  axi_strb_t s_buf [$];
  bit aw_seen, w_seen, b_pend, b_taken, r_pend, r_taken;
  axi_addr_t aw_addr_q, ar_addr_q;
  axi_id_t aw_id_q, ar_id_q;
  axi_len_t ar_len_q, r_beat;

  always #(PERIOD / 2) clk_i = ~clk_i;

  axi4_adapter u_axi4_adapter (.*);

  adapter_checker u_adapter_checker (
    .clk_i(clk_i), .rst_ni(rst_ni), .req_i(req_i), .we_i(we_i), .gnt_i(gnt_o),
    .busy_i(busy_o), .valid_i(valid_o), .kind_i(kind_i), .addr_i(addr_i), .ar_addr_i(ar_addr_o),
    .id_i(id_i), .rid_i(id_o), .b_id_i(b_id_i), .wdata_i(wdata_i), .rdata_i(rdata_o), .be_i(be_i),
    .size_i(size_i), .aw_size_i(aw_size_o), .ar_size_i(ar_size_o),
    .aw_cache_i(aw_cache_o), .ar_cache_i(ar_cache_o),
    .aw_valid_i(aw_valid_o), .aw_ready_i(aw_ready_i), .w_valid_i(w_valid_o),
    .b_valid_i(b_valid_i), .b_ready_i(b_ready_o), .ar_valid_i(ar_valid_o),
    .ar_ready_i(ar_ready_i), .r_valid_i(r_valid_i), .r_ready_i(r_ready_o), .r_last_i(r_last_i),
    .aw_len_i(aw_len_o), .ar_len_i(ar_len_o), .aw_burst_i(aw_burst_o), .ar_burst_i(ar_burst_o),
    .done_o(done), .errors_o(errors)
  );

  function automatic axi_data_t read_word(input int unsigned wa);
    return mem.exists(wa) ? mem[wa] : {wa ^ 32'ha5a5_0f0f, wa * 32'h9e37_79b1};
  endfunction

  function automatic logic rand_ready();
    return ($urandom % 3) != 0;
  endfunction

  // merge the buffered W beats into memory at the AW address
  task automatic commit_write();
    int unsigned wa;
    axi_data_t d;
    axi_strb_t s;
    axi_data_t word;
    wa = aw_addr_q >> 3;
    while (w_buf.size() > 0) begin
      d = w_buf.pop_front();
      s = s_buf.pop_front();
      word = read_word(wa);
      for (int b = 0; b < 8; b++) begin
        if (s[0]) word = (word & ~(64'hff << (8 * b))) | (d & (64'hff << (8 * b)));
        s = s >> 1;
      end
      mem[wa] = word;
      wa++;
    end
  endtask

  // --------------------
  // subordinate, observe
  // --------------------
  always @(posedge clk_i) begin
    if (aw_valid_o && aw_ready_i) begin
      aw_seen = 1'b1;
      aw_addr_q = aw_addr_o;
      aw_id_q = aw_id_o;
    end
    if (w_valid_o && w_ready_i) begin
      w_buf.push_back(w_data_o);
      s_buf.push_back(w_strb_o);
      if (w_last_o) w_seen = 1'b1;
    end
    if (aw_seen && w_seen) begin
      commit_write();
      aw_seen = 1'b0;
      w_seen = 1'b0;
      b_pend = 1'b1;
    end
    if (b_valid_i && b_ready_o) begin
      b_pend = 1'b0;
      b_taken = 1'b1;
    end
    if (ar_valid_o && ar_ready_i) begin
      r_pend = 1'b1;
      ar_addr_q = ar_addr_o;
      ar_id_q = ar_id_o;
      ar_len_q = ar_len_o;
      r_beat = '0;
    end
    if (r_valid_i && r_ready_o) begin
      r_taken = 1'b1;
      if (r_last_i) r_pend = 1'b0;
      else r_beat = r_beat + 8'd1;
    end
  end

  // --------------------
  // subordinate, drive
  // --------------------
  always @(negedge clk_i) begin
    // the random stream advances every cycle, in reset or not
    aw_ready_i = rand_ready() && rst_ni;
    w_ready_i = rand_ready() && rst_ni;
    ar_ready_i = rand_ready() && rst_ni;
    // a pending beat that was not taken stays on the bus
    if (!(b_valid_i && !b_taken)) begin
      b_valid_i = rst_ni && b_pend && rand_ready();
      b_id_i = aw_id_q;
    end
    if (!(r_valid_i && !r_taken)) begin
      r_valid_i = rst_ni && r_pend && rand_ready();
      r_data_i = read_word((ar_addr_q >> 3) + 32'(r_beat));
      r_last_i = (r_beat == ar_len_q);
      r_id_i = ar_id_q;
    end
    b_taken = 1'b0;
    r_taken = 1'b0;
  end

  task automatic run_case(input logic [9:0] b);
    @(negedge clk_i);
    we_i = cases[b][0];
    kind_i = req_kind_t'(cases[b + 10'd1][0]);
    addr_i = axi_addr_t'(cases[b + 10'd2]);
    id_i = axi_id_t'(cases[b + 10'd3]);
    wdata_i = {cases[b + 10'd7], cases[b + 10'd6], cases[b + 10'd5], cases[b + 10'd4]};
    be_i = {8'(cases[b + 10'd11]), 8'(cases[b + 10'd10]), 8'(cases[b + 10'd9]),
            8'(cases[b + 10'd8])};
    req_i = 1'b1;
    do @(posedge clk_i); while (!gnt_o);
    @(negedge clk_i);
    req_i = 1'b0;
    do @(posedge clk_i); while (!valid_o);
  endtask

  initial begin
    logic [9:0] pos;
    void'($urandom(32'hed17));
    for (int i = 0; i < 1024; i++) cases[i] = '1;
    $readmemh("tests/adapter_cases.txt", cases);
    pos = '0;
    while (pos <= 10'd1008 && cases[pos] != '1) begin
      num_cases++;
      pos = pos + 10'd12;
    end
    loaded = 1'b1;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    pos = '0;
    for (int unsigned c = 0; c < num_cases; c++) begin
      run_case(pos);
      pos = pos + 10'd12;
    end
    repeat (2) @(posedge clk_i);
    $display("%0d of %0d tests done, %0d errors", done, num_cases, errors);
    if (errors == 0 && done == num_cases) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    wait (loaded);
    #((num_cases + 1) * CYCLES_PER_CASE * PERIOD);
    $display("timeout: %0d of %0d tests finished before the time limit", done, num_cases);
    $display("TESTS FAILED");
    $finish;
  end

endmodule
